//--- design/status_net_config.svh
`ifndef STATUS_NET_CONFIG_SVH
`define STATUS_NET_CONFIG_SVH

// channel FIFO size, entries = 2**N
`define STATUS_FIFO_DEPTH_LOG2 4

// bytes per source packet, header + 2 payload
`define STATUS_PKT_BYTES 3

`endif

//--- design/status_net_pkg.sv
package status_net_pkg;

    typedef logic [7:0]  status_byte_t;   // one link byte
    typedef logic [15:0] status_word_t;   // status payload
    typedef logic        src_id_t;        // header msb
    typedef logic [6:0]  seq_t;           // header low bits
    typedef logic [8:0]  fifo_entry_t;    // {last, data}

    typedef enum logic [1:0] {
        SRC_IDLE,      // waiting for send
        SRC_REQUEST,   // rq up, header on db
        SRC_STREAM     // payload bytes going out
    } src_state_t;

    typedef enum logic {
        SNK_IDLE,      // ready for a new packet
        SNK_RECEIVE    // collecting bytes until rq drops
    } snk_state_t;

endpackage

//--- design/fifo_if.sv
`timescale 1ns/1ns

interface fifo_if import status_net_pkg::*; ();

    logic        we;          // push, from router
    logic        re;          // pop, from router
    fifo_entry_t wdata;       // last flag + byte
    fifo_entry_t rdata;       // head entry, combinational
    logic        nempty;      // at least one entry
    logic        half_full;   // stop granting new packets

    modport router (
        output we, re, wdata,
        input  rdata, nempty, half_full
    );

    modport fifo (
        input  we, re, wdata,
        output rdata, nempty, half_full
    );

endinterface

//--- design/status_fifo.sv
`timescale 1ns/1ns
`include "status_net_config.svh"

module status_fifo import status_net_pkg::*; (
    input logic  clk,
    input logic  rst,        // async, active high
    fifo_if.fifo f           // router drives we/re/wdata
);

    localparam int AW    = `STATUS_FIFO_DEPTH_LOG2;   // pointer width
    localparam int DEPTH = 1 << AW;                    // entry count

    fifo_entry_t   mem [DEPTH];   // register array
    logic [AW-1:0] wptr;          // next free slot
    logic [AW-1:0] rptr;          // head slot
    logic [AW:0]   count;         // 0..DEPTH entries held

    assign f.rdata     = mem[rptr];                          // head visible with nempty
    assign f.nempty    = (count != '0);
    assign f.half_full = (count >= (AW + 1)'(DEPTH / 2));     // leaves room for a full packet

    // storage only, pointers below carry the state
    always_ff @(posedge clk) begin
        if (f.we) begin
            mem[wptr] <= f.wdata;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wptr  <= '0;
            rptr  <= '0;
            count <= '0;
        end else begin
            if (f.we) begin
                wptr <= wptr + 1'b1;   // wraps at DEPTH
            end
            if (f.re) begin
                rptr <= rptr + 1'b1;
            end
            case ({f.we, f.re})
                2'b10:   count <= count + 1'b1;   // push only
                2'b01:   count <= count - 1'b1;   // pop only
                default: count <= count;          // both or neither
            endcase
        end
    end

endmodule

//--- design/status_source.sv
`timescale 1ns/1ns
`include "status_net_config.svh"

module status_source import status_net_pkg::*; #(
    parameter src_id_t SRC_ID = 1'b0      // channel number in header msb
) (
    input  logic         clk,
    input  logic         rst,
    input  logic         send,     // one-cycle strobe
    input  status_word_t word,     // sampled with send
    output logic         busy,     // send ignored while high
    output status_byte_t db,       // link byte
    output logic         rq,       // link request, low on last byte
    input  logic         start     // first byte taken this cycle
);

    localparam int PKT_W = `STATUS_PKT_BYTES * 8;        // packet bits
    localparam int CW    = $clog2(`STATUS_PKT_BYTES);     // byte counter width

    src_state_t       state;
    seq_t             seq;      // number for the next packet
    logic [PKT_W-1:0] pkt;      // outgoing bytes, msb byte on db
    logic [CW-1:0]    left;     // bytes still to come after db

    assign db   = pkt[PKT_W-1 -: 8];
    assign rq   = (state == SRC_REQUEST) ||
                  (state == SRC_STREAM && left != '0);   // drops with final byte
    assign busy = send || (state != SRC_IDLE);            // covers the strobe cycle

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= SRC_IDLE;
            seq   <= '0;
            left  <= '0;
        end else begin
            case (state)
                SRC_IDLE: begin
                    if (send) begin
                        state <= SRC_REQUEST;
                        seq   <= seq + 1'b1;   // one step per packet
                    end
                end
                SRC_REQUEST: begin
                    if (start) begin
                        state <= SRC_STREAM;
                        left  <= CW'(`STATUS_PKT_BYTES - 2);   // header gone, payload hi next
                    end
                end
                SRC_STREAM: begin
                    if (left == '0) begin
                        state <= SRC_IDLE;      // final byte out this cycle
                    end else begin
                        left <= left - 1'b1;
                    end
                end
                default: state <= SRC_IDLE;
            endcase
        end
    end

    // packet shifter, loaded on accepted send
    always_ff @(posedge clk) begin
        if (state == SRC_IDLE && send) begin
            pkt <= {SRC_ID, seq, word};              // header then payload
        end else if ((state == SRC_REQUEST && start) || state == SRC_STREAM) begin
            pkt <= {pkt[PKT_W-9:0], 8'h00};          // next byte up
        end
    end

endmodule

//--- design/status_router2.sv
`timescale 1ns/1ns

module status_router2 import status_net_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  status_byte_t db_in0,
    input  status_byte_t db_in1,
    input  logic         rq_in0,
    input  logic         rq_in1,
    output logic         start_in0,   // combinational grant on first byte
    output logic         start_in1,
    output status_byte_t db_out,      // merged stream
    output logic         rq_out,
    input  logic         start_out    // sink took first byte
);

    fifo_if f0 ();   // channel 0 buffer
    fifo_if f1 ();   // channel 1 buffer

    logic [1:0] rq_in;
    logic [1:0] start_rcv;       // grant on input link
    logic [1:0] rcv_rest_r;      // taking bytes after the first
    logic [1:0] half_full;
    logic [1:0] head_last;       // head entry is a packet end
    logic [1:0] nempty_pre;      // raw fifo flag
    logic [1:0] nempty;          // last-byte entries hidden
    logic [1:0] fifo_re;
    logic       next_chn;        // preferred channel when both wait
    logic       cur_chn_r;       // channel being sent out
    logic       snd_rest_r;      // sending bytes after the first
    logic       chn_sel;         // pick for a new packet
    logic       snd_last;        // final byte of current packet at head
    logic       snd_pre_start;   // may choose a channel now
    logic       early_chn;       // channel steering db_out

    assign rq_in      = {rq_in1, rq_in0};
    assign half_full  = {f1.half_full, f0.half_full};
    assign nempty_pre = {f1.nempty, f0.nempty};
    assign head_last  = {f1.rdata[8], f0.rdata[8]};

    // no new packet into a half full buffer
    assign start_rcv = ~half_full & ~rcv_rest_r & rq_in;
    assign start_in0 = start_rcv[0];
    assign start_in1 = start_rcv[1];

    assign f0.we    = start_rcv[0] | rcv_rest_r[0];
    assign f1.we    = start_rcv[1] | rcv_rest_r[1];
    assign f0.wdata = {rcv_rest_r[0] & ~rq_in[0], db_in0};   // flag set on rq drop
    assign f1.wdata = {rcv_rest_r[1] & ~rq_in[1], db_in1};

    // output side
    assign nempty        = nempty_pre & ~head_last;            // a lone tail does not start a packet
    assign chn_sel       = (&nempty) ? next_chn : nempty[1];
    assign fifo_re       = start_out  ? {chn_sel, ~chn_sel} :
                           snd_rest_r ? {cur_chn_r, ~cur_chn_r} : 2'b00;
    assign f0.re         = fifo_re[0];
    assign f1.re         = fifo_re[1];
    assign snd_last      = cur_chn_r ? (nempty_pre[1] & head_last[1]) :
                                       (nempty_pre[0] & head_last[0]);
    assign snd_pre_start = (|nempty) & (~snd_rest_r | snd_last);
    assign rq_out        = (snd_rest_r | (|nempty)) & ~snd_last;   // low with the final byte
    assign early_chn     = snd_rest_r ? cur_chn_r : chn_sel;
    assign db_out        = early_chn ? f1.rdata[7:0] : f0.rdata[7:0];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rcv_rest_r <= 2'b00;
            next_chn   <= 1'b0;
            cur_chn_r  <= 1'b0;
            snd_rest_r <= 1'b0;
        end else begin
            rcv_rest_r <= (rcv_rest_r & rq_in) | start_rcv;   // held until rq drops
            if (|fifo_re) begin
                next_chn <= fifo_re[0];                        // other side preferred next
            end
            if (snd_pre_start) begin
                cur_chn_r <= chn_sel;
            end
            snd_rest_r <= (snd_rest_r & ~snd_last) | start_out;
        end
    end

    status_fifo u_fifo0 (
        .clk (clk),
        .rst (rst),
        .f   (f0.fifo)
    );

    status_fifo u_fifo1 (
        .clk (clk),
        .rst (rst),
        .f   (f1.fifo)
    );

endmodule

//--- design/status_sink.sv
`timescale 1ns/1ns
`include "status_net_config.svh"

module status_sink import status_net_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  status_byte_t db,          // from router
    input  logic         rq,
    output logic         start,       // combinational grant
    output logic         pkt_valid,   // one-cycle strobe
    output src_id_t      pkt_src,
    output seq_t         pkt_seq,
    output status_word_t pkt_word
);

    localparam int PAY_W = (`STATUS_PKT_BYTES - 1) * 8;   // payload bits after header

    snk_state_t       state;
    status_byte_t     hdr;      // first byte of packet
    logic [PAY_W-1:0] pay;      // payload shifter

    assign start    = (state == SNK_IDLE) && rq;   // takes the header now
    assign pkt_src  = hdr[$bits(seq_t)];           // id above the sequence bits
    assign pkt_seq  = hdr[$bits(seq_t)-1:0];
    assign pkt_word = pay;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= SNK_IDLE;
            pkt_valid <= 1'b0;
        end else begin
            pkt_valid <= (state == SNK_RECEIVE) && !rq;   // final byte taken
            case (state)
                SNK_IDLE: begin
                    if (start) begin
                        state <= SNK_RECEIVE;
                    end
                end
                SNK_RECEIVE: begin
                    if (!rq) begin
                        state <= SNK_IDLE;   // ready again next cycle
                    end
                end
                default: state <= SNK_IDLE;
            endcase
        end
    end

    // data capture, fields stay put through pkt_valid
    always_ff @(posedge clk) begin
        if (start) begin
            hdr <= db;
        end
        if (state == SNK_RECEIVE) begin
            pay <= {pay[PAY_W-9:0], db};   // hi byte first
        end
    end

endmodule

//--- design/status_net_top.sv
`timescale 1ns/1ns

module status_net_top import status_net_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  logic         send0,       // strobes, one cycle
    input  logic         send1,
    input  status_word_t word0,
    input  status_word_t word1,
    output logic         busy0,
    output logic         busy1,
    output logic         pkt_valid,   // one cycle per packet
    output src_id_t      pkt_src,
    output seq_t         pkt_seq,
    output status_word_t pkt_word
);

    status_byte_t db0, db1, db_out;   // link bytes
    logic         rq0, rq1, rq_out;   // link requests
    logic         start0, start1, start_out;

    status_source #(.SRC_ID(1'b0)) u_src0 (
        .clk (clk), .rst (rst),
        .send (send0), .word (word0), .busy (busy0),
        .db (db0), .rq (rq0), .start (start0)
    );

    status_source #(.SRC_ID(1'b1)) u_src1 (
        .clk (clk), .rst (rst),
        .send (send1), .word (word1), .busy (busy1),
        .db (db1), .rq (rq1), .start (start1)
    );

    status_router2 u_router (
        .clk (clk), .rst (rst),
        .db_in0 (db0), .db_in1 (db1),
        .rq_in0 (rq0), .rq_in1 (rq1),
        .start_in0 (start0), .start_in1 (start1),
        .db_out (db_out), .rq_out (rq_out), .start_out (start_out)
    );

    status_sink u_sink (
        .clk (clk), .rst (rst),
        .db (db_out), .rq (rq_out), .start (start_out),
        .pkt_valid (pkt_valid), .pkt_src (pkt_src),
        .pkt_seq (pkt_seq), .pkt_word (pkt_word)
    );

endmodule

//--- tests/status_net_chk.sv
`timescale 1ns/1ns
`include "status_net_config.svh"

module status_net_chk (
    input logic                           clk,
    input logic                           rst,
    input logic                           start_out,   // router to sink link
    input logic                           rq_out,
    input logic                           pkt_valid,
    input logic                           start_in0,   // source links
    input logic                           rq_in0,
    input logic                           start_in1,
    input logic                           rq_in1,
    input logic                           we0,         // channel fifo pushes
    input logic                           we1,
    input logic [`STATUS_FIFO_DEPTH_LOG2:0] count0,
    input logic [`STATUS_FIFO_DEPTH_LOG2:0] count1
);

    localparam int AW = `STATUS_FIFO_DEPTH_LOG2;
    localparam logic [AW:0] FULL = {1'b1, {AW{1'b0}}};   // all entries in use

    a_start_out_rq: assert property (@(posedge clk) disable iff (rst) start_out |-> rq_out)
        else $error("start_out high while rq_out low");

    a_valid_strobe: assert property (@(posedge clk) disable iff (rst) pkt_valid |=> !pkt_valid)
        else $error("pkt_valid held for two cycles");

    a_start_in0_rq: assert property (@(posedge clk) disable iff (rst) $rose(start_in0) |-> rq_in0)
        else $error("start_in0 rose without rq_in0");

    a_start_in1_rq: assert property (@(posedge clk) disable iff (rst) $rose(start_in1) |-> rq_in1)
        else $error("start_in1 rose without rq_in1");

    a_fifo0_room: assert property (@(posedge clk) disable iff (rst) we0 |-> (count0 != FULL))
        else $error("write into full channel 0 fifo");

    a_fifo1_room: assert property (@(posedge clk) disable iff (rst) we1 |-> (count1 != FULL))
        else $error("write into full channel 1 fifo");

endmodule

//--- tests/tb_status_net.sv
`timescale 1ns/1ns

module tb_status_net import status_net_pkg::*; ();

    logic         clk;
    logic         rst;
    logic         send0;
    logic         send1;
    status_word_t word0;
    status_word_t word1;
    logic         busy0;
    logic         busy1;
    logic         pkt_valid;
    src_id_t      pkt_src;
    seq_t         pkt_seq;
    status_word_t pkt_word;

    logic [31:0]  lfsr;            // galois state
    status_word_t exp_q0[$];       // words sent, not yet seen
    status_word_t exp_q1[$];
    seq_t         exp_seq[2];      // next sequence per source
    src_id_t      rx_src_q[$];     // packets caught by the monitor
    seq_t         rx_seq_q[$];
    status_word_t rx_word_q[$];
    int           err_value;
    int           err_order;
    int           err_timeout;

    status_net_top u_status_net_top (.*);

    bind status_net_top status_net_chk u_chk (
        .clk (clk), .rst (rst), .start_out (start_out), .rq_out (rq_out),
        .pkt_valid (pkt_valid), .start_in0 (start0), .rq_in0 (rq0),
        .start_in1 (start1), .rq_in1 (rq1),
        .we0 (u_router.f0.we), .we1 (u_router.f1.we),
        .count0 (u_router.u_fifo0.count), .count1 (u_router.u_fifo1.count)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;   // 10 ns period
    end

    always @(negedge clk) begin
        if (!rst && pkt_valid) begin   // fields stable mid cycle
            rx_src_q.push_back(pkt_src);
            rx_seq_q.push_back(pkt_seq);
            rx_word_q.push_back(pkt_word);
        end
    end

    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] v;
        int          i;
        v = '0;
        for (i = 0; i < n; i++) begin
            v    = {v[14:0], lfsr[0]};
            lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);   // one step per bit
        end
        return v;
    endfunction

    task automatic check_flag(input logic got, exp, input string what);
        if (got !== exp) begin
            err_value++;
            $display("ERR %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_src(input src_id_t got, exp, input string what);
        if (got !== exp) begin
            err_value++;
            $display("ERR %0t: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_seq(input seq_t got, exp, input string what);
        if (got !== exp) begin
            err_value++;
            $display("ERR %0t: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_word(input status_word_t got, exp, input string what);
        if (got !== exp) begin
            err_value++;
            $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic wait_not_busy(input src_id_t s);
        int t;
        t = 0;
        while ((s ? busy1 : busy0) && t < 100) begin
            @(posedge clk);
            #1;
            t++;
        end
        if (s ? busy1 : busy0) begin
            err_timeout++;
            $display("timeout: source %0d stayed busy", s);
        end
    endtask

    task automatic wait_rx(input int n);
        int t;
        t = 0;
        while (rx_src_q.size() < n && t < 500) begin
            @(posedge clk);
            #1;
            t++;
        end
        if (rx_src_q.size() < n) begin
            err_timeout++;
            $display("timeout: %0d of %0d packets arrived", rx_src_q.size(), n);
        end
    endtask

    // called at edge + 1, returns at edge + 1
    task automatic pulse_send(input logic s0, s1, input status_word_t w0, w1);
        send0 = s0;
        send1 = s1;
        word0 = w0;
        word1 = w1;
        @(posedge clk);
        #1;
        send0 = 1'b0;
        send1 = 1'b0;
    endtask

    task automatic send_pair(input logic s0, s1, input status_word_t w0, w1);
        if (s0) wait_not_busy(1'b0);
        if (s1) wait_not_busy(1'b1);
        if (s0) exp_q0.push_back(w0);
        if (s1) exp_q1.push_back(w1);
        pulse_send(s0, s1, w0, w1);
    endtask

    task automatic match_packet(input src_id_t s, input seq_t q, input status_word_t w);
        status_word_t exp_w;
        if ((s ? exp_q1.size() : exp_q0.size()) == 0) begin
            err_order++;
            $display("unexpected packet from source %0d, seq %0d, word %h", s, q, w);
        end else begin
            if (s) exp_w = exp_q1.pop_front();
            else   exp_w = exp_q0.pop_front();
            check_seq(q, exp_seq[s], "sequence");
            check_word(w, exp_w, "payload");
            exp_seq[s] = exp_seq[s] + 1'b1;
        end
    endtask

    // wait for every outstanding packet, then a quiet gap to catch extras
    task automatic drain_check();
        wait_rx(exp_q0.size() + exp_q1.size());
        repeat (20) @(posedge clk);
        #1;
        while (rx_src_q.size() > 0) begin
            match_packet(rx_src_q.pop_front(), rx_seq_q.pop_front(), rx_word_q.pop_front());
        end
        if (exp_q0.size() + exp_q1.size() != 0) begin
            err_order++;
            $display("packets lost: %0d from source 0, %0d from source 1",
                     exp_q0.size(), exp_q1.size());
            exp_q0.delete();
            exp_q1.delete();
        end
    endtask

    task automatic test_reset_state();
        check_flag(pkt_valid, 1'b0, "pkt_valid after reset");
        check_flag(busy0, 1'b0, "busy0 after reset");
        check_flag(busy1, 1'b0, "busy1 after reset");
    endtask

    task automatic test_single(input src_id_t s, input status_word_t w);
        send_pair(!s, s, w, w);
        wait_rx(1);
        if (rx_src_q.size() > 0) check_src(rx_src_q[0], s, "packet source");
        drain_check();
    endtask

    task automatic test_repeated_pairs(input int n);
        int i;
        for (i = 0; i < n; i++) begin
            send_pair(1'b1, 1'b1, status_word_t'(16'h0100 + i), status_word_t'(16'h8200 + i));
        end
        drain_check();   // order and count per source
    endtask

    task automatic test_random_stream(input int n);
        int           sent0;
        int           sent1;
        int           cyc;
        logic         go0;
        logic         go1;
        status_word_t w0;
        status_word_t w1;
        sent0 = 0;
        sent1 = 0;
        cyc   = 0;
        w0    = '0;
        w1    = '0;
        while ((sent0 < n || sent1 < n) && cyc < 3000) begin
            go0 = 1'b0;
            go1 = 1'b0;
            if (!busy0 && sent0 < n) go0 = (rand_bits(2) == 16'd0);   // busy read before drive
            if (!busy1 && sent1 < n) go1 = (rand_bits(2) == 16'd0);
            if (go0) begin
                w0 = rand_bits(16);
                exp_q0.push_back(w0);
                sent0++;
            end
            if (go1) begin
                w1 = rand_bits(16);
                exp_q1.push_back(w1);
                sent1++;
            end
            send0 = go0;
            send1 = go1;
            word0 = w0;
            word1 = w1;
            @(posedge clk);
            #1;
            cyc++;
        end
        send0 = 1'b0;
        send1 = 1'b0;
        if (sent0 < n || sent1 < n) begin
            err_timeout++;
            $display("timeout: random stream sent only %0d and %0d words", sent0, sent1);
        end
        drain_check();
    endtask

    task automatic test_send_while_busy();
        wait_not_busy(1'b0);
        exp_q0.push_back(16'h5a5a);
        pulse_send(1'b1, 1'b0, 16'h5a5a, 16'h0000);
        check_flag(busy0, 1'b1, "busy0 after send");
        pulse_send(1'b1, 1'b0, 16'hdead, 16'h0000);   // dropped by source
        drain_check();
        test_single(1'b0, 16'h0f0f);                   // seq moved by one only
    endtask

    initial begin
        rst         = 1'b1;
        send0       = 1'b0;
        send1       = 1'b0;
        word0       = '0;
        word1       = '0;
        lfsr        = 32'hcf8c_cc52;
        exp_seq[0]  = '0;
        exp_seq[1]  = '0;
        err_value   = 0;
        err_order   = 0;
        err_timeout = 0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        test_reset_state();
        test_single(1'b0, 16'hc3a5);
        test_single(1'b1, 16'h3c5a);
        send_pair(1'b1, 1'b1, 16'h1234, 16'habcd);
        drain_check();
        test_repeated_pairs(6);
        test_random_stream(12);
        test_send_while_busy();
        $display("errors: value %0d, order %0d, timeout %0d", err_value, err_order, err_timeout);
        if (err_value + err_order + err_timeout == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin
        #200000;
        $display("run stopped by watchdog before the tests completed");
        $display("TEST FAIL");
        $finish;
    end

endmodule

//--- src.f
+incdir+design
design/status_net_pkg.sv
design/fifo_if.sv
design/status_fifo.sv
design/status_source.sv
design/status_router2.sv
design/status_sink.sv
design/status_net_top.sv
tests/status_net_chk.sv
tests/tb_status_net.sv

//--- run_sim.sh
#!/bin/sh
# build and run the status network testbench, result taken from the output
verilator --binary --timing --assert --top-module tb_status_net -f src.f -o tb_status_net \
    && out=$(./obj_dir/tb_status_net) \
    && echo "$out" \
    && echo "$out" | grep -q "TEST PASS" \
    && echo "simulation passed" \
    || { echo "$out"; echo "simulation failed"; exit 1; }
